// ==== sources.f ====
+incdir+test
common/div_pkg.sv
common/div_req_if.sv
rtl/div_req_queue.sv
divider/div_ctrl.sv
divider/div_dpath.sv
divider/int_div_iterative.sv
rtl/div_unit_top.sv
test/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the divide unit testbench with Verilator and runs it
# exit status is zero only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module div_unit_tb -f sources.f -o div_unit_sim \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/div_unit_sim)
echo "$out"
echo "$out" | grep -q "All tests passed" && exit 0 || exit 1

// ==== test/div_tb_model.svh ====
/*
  reference division model and xorshift generator for the divide unit testbench
  included inside the testbench module body
*/
`ifndef DIV_TB_MODEL_SVH
`define DIV_TB_MODEL_SVH

// 32-bit xorshift, returns the next state
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected response word, remainder on top and quotient below
function automatic logic [63:0] div_model(input logic fn, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [31:0] q_mag;
  logic [31:0] r_mag;
  logic [31:0] q;
  logic [31:0] r;
  // magnitudes only matter for signed requests
  a_mag = (fn && a[31]) ? (~a + 32'd1) : a;
  b_mag = (fn && b[31]) ? (~b + 32'd1) : b;
  // zero divisor gives all ones and the dividend back
  if (b_mag == 32'd0) begin
    q_mag = 32'hffff_ffff;
    r_mag = a_mag;
  end else begin
    q_mag = a_mag / b_mag;
    r_mag = a_mag % b_mag;
  end
  // quotient negative when exactly one operand is negative
  q = (fn && (a[31] ^ b[31])) ? (~q_mag + 32'd1) : q_mag;
  // remainder follows the dividend
  r = (fn && a[31]) ? (~r_mag + 32'd1) : r_mag;
  return {r, q};
endfunction

`endif

// ==== test/div_unit_tb.sv ====
`timescale 1ns/1ps
/*
  testbench for the divide unit top level
  random and corner requests checked against a reference model in request order
*/
module div_unit_tb;

  localparam int          CLK_PERIOD  = 100;
  localparam int          QUEUE_DEPTH = 4;
  localparam logic [31:0] SEED        = 32'd75;

  // request counts per test, also used to size the watchdog
  localparam int N_UNSIGNED  = 20;
  localparam int N_SIGNED    = 20;
  localparam int N_CORNER    = 6;
  localparam int N_ZERO      = 6;
  localparam int N_BP        = 20;
  localparam int FILL_CYCLES = 60;
  localparam int TOTAL_REQS  = N_UNSIGNED + N_SIGNED + N_CORNER + N_ZERO + N_BP
                               + QUEUE_DEPTH + 1;
  localparam int WATCHDOG_NS = (TOTAL_REQS * 40 + FILL_CYCLES + 100) * CLK_PERIOD;

  // longest drain of a full queue plus divider under random back-pressure
  localparam int DRAIN_CYCLES = (QUEUE_DEPTH + 1) * 80;

  logic        clk;
  logic        reset;
  logic        req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        req_val;
  logic        req_rdy;
  logic [63:0] resp_result;
  logic        resp_val;
  logic        resp_rdy;

  // generator states
  logic [31:0] rng;
  logic [31:0] bp_rng;
  logic        bp_random;

  // scoreboard of expected results in request order
  logic [63:0] exp_q[$];
  logic        hold_armed;
  logic [63:0] held_result;

  int err_count;
  int check_count;
  int tests_failed;
  int test_errs_at_start;

  `include "div_tb_model.svh"

  div_unit_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) div_unit_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
      err_count++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // offer one request and return on the edge that takes it
  task automatic send_request(input logic fn, input logic [31:0] a, input logic [31:0] b);
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    req_val <= 1'b0;
  endtask

  // random operands, divisor shifted down so quotients vary in size
  task automatic send_random(input logic fn);
    logic [31:0] r;
    logic [31:0] b;
    r = next_rand();
    b = next_rand() >> r[4:0];
    if (fn && r[5]) begin
      b = ~b + 32'd1;
    end
    send_request(fn, next_rand(), b);
  endtask

  // polls the scoreboard at falling edges until it empties or the drain limit runs out
  // leftover entries mean lost responses
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    check_value("scoreboard depth", 64'(exp_q.size()), 64'd0);
    @(posedge clk);
  endtask

  task automatic start_test();
    test_errs_at_start = err_count;
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = err_count - test_errs_at_start;
    if (errs == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  // ---------------------------------------------------------------------
  // scoreboard and hold monitor
  // ---------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      hold_armed = 1'b0;
    end else begin
      if (req_val && req_rdy) begin
        exp_q.push_back(div_model(req_fn, req_a, req_b));
      end
      // a stalled response must not move
      if (hold_armed) begin
        check_value("resp_val", 64'(resp_val), 64'd1);
        check_value("resp_result", resp_result, held_result);
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("response arrived with no request outstanding");
        end else begin
          check_value("resp_result", resp_result, exp_q.pop_front());
        end
      end
      hold_armed  = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  // random back-pressure on its own generator
  always @(posedge clk) begin
    if (bp_random) begin
      bp_rng = xorshift32(bp_rng);
      resp_rdy <= bp_rng[3];
    end
  end

  // ---------------------------------------------------------------------
  // watchdog
  // ---------------------------------------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("run timed out before all tests finished");
    $display("Some tests failed");
    $finish;
  end

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------

  initial begin
    int accepted;
    rng          = SEED;
    bp_rng       = ~SEED;
    err_count    = 0;
    check_count  = 0;
    tests_failed = 0;
    reset     <= 1'b1;
    req_fn    <= 1'b0;
    req_a     <= '0;
    req_b     <= '0;
    req_val   <= 1'b0;
    resp_rdy  <= 1'b1;
    bp_random <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // outputs right after reset, nothing sent yet
    start_test();
    @(posedge clk);
    check_value("resp_val", 64'(resp_val), 64'd0);
    check_value("req_rdy", 64'(req_rdy), 64'd1);
    report_test("reset state");

    start_test();
    repeat (N_UNSIGNED) send_random(1'b0);
    wait_drain();
    report_test("unsigned random");

    // random signed plus the most negative value and mixed signs
    start_test();
    repeat (N_SIGNED) send_random(1'b1);
    send_request(1'b1, 32'h8000_0000, 32'hffff_ffff);
    send_request(1'b1, 32'h8000_0000, 32'd1);
    send_request(1'b1, -32'sd7, 32'd2);
    send_request(1'b1, 32'd7, -32'sd2);
    send_request(1'b1, -32'sd7, -32'sd2);
    send_request(1'b1, 32'h7fff_ffff, 32'h8000_0000);
    wait_drain();
    report_test("signed random");

    start_test();
    send_request(1'b0, 32'd123, 32'd0);
    send_request(1'b0, 32'd0, 32'd0);
    send_request(1'b0, 32'hffff_ffff, 32'd0);
    send_request(1'b1, -32'sd5, 32'd0);
    send_request(1'b1, 32'd5, 32'd0);
    send_request(1'b1, 32'h8000_0000, 32'd0);
    wait_drain();
    report_test("divide by zero");

    start_test();
    bp_random <= 1'b1;
    repeat (N_BP) send_random(next_rand() > 32'h8000_0000);
    wait_drain();
    bp_random <= 1'b0;
    @(posedge clk);
    resp_rdy <= 1'b1;
    wait_drain();
    report_test("response back-pressure");

    // stall the output and offer a request every cycle
    start_test();
    accepted = 0;
    resp_rdy <= 1'b0;
    req_fn   <= next_rand() > 32'h8000_0000;
    req_a    <= next_rand();
    req_b    <= next_rand() >> 8;
    req_val  <= 1'b1;
    repeat (FILL_CYCLES) begin
      @(posedge clk);
      if (req_rdy) begin
        accepted++;
        req_fn <= next_rand() > 32'h8000_0000;
        req_a  <= next_rand();
        req_b  <= next_rand() >> 8;
      end
    end
    req_val <= 1'b0;
    check_value("accepted requests", 64'(accepted), 64'(QUEUE_DEPTH + 1));
    check_value("req_rdy", 64'(req_rdy), 64'd0);
    resp_rdy <= 1'b1;
    wait_drain();
    report_test("queue fill");

    $display("6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== rtl/div_unit_top.sv ====
`timescale 1ns/1ps
/*
  divide unit top level with the request queue feeding the divider
  plain val/rdy ports on both the request and the response side
*/
module div_unit_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  div_pkg::div_fn_t req_fn,
  input  div_pkg::word_t   req_a,
  input  div_pkg::word_t   req_b,
  input  logic             req_val,
  output logic             req_rdy,
  output div_pkg::result_t resp_result,
  output logic             resp_val,
  input  logic             resp_rdy
);

  // queue head to divider
  div_req_if req_bus ();

  // ---------------------------------------------------------------------
  // request queue
  // ---------------------------------------------------------------------

  div_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) req_queue (
    .clk     (clk),
    .reset   (reset),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .deq     (req_bus.source)
  );

  // ---------------------------------------------------------------------
  // divider
  // ---------------------------------------------------------------------

  int_div_iterative divider (
    .clk         (clk),
    .reset       (reset),
    .req         (req_bus.sink),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

// ==== divider/int_div_iterative.sv ====
`timescale 1ns/1ps
/*
  iterative divider holding one operation at a time
  takes requests from the queue interface and drives the response ports
*/
module int_div_iterative (
  input  logic             clk,
  input  logic             reset,
  div_req_if.sink          req,
  output div_pkg::result_t resp_result,
  output logic             resp_val,
  input  logic             resp_rdy
);

  // control to datapath
  logic load;
  logic step;

  // ---------------------------------------------------------------------
  // control
  // ---------------------------------------------------------------------

  div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req.val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req.rdy),
    .resp_val (resp_val),
    .load     (load),
    .step     (step)
  );

  // ---------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------

  // result comes straight off the sign fix-up muxes
  // registers are idle in done so it stays put under back-pressure
  div_dpath dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .fn     (req.fn),
    .a      (req.a),
    .b      (req.b),
    .result (resp_result)
  );

endmodule

// ==== divider/div_dpath.sv ====
`timescale 1ns/1ps
/*
  divider datapath with operand magnitudes, restoring shift-subtract
  registers and the final sign fix-up, sequenced by load and step
*/
module div_dpath (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic             step,
  input  div_pkg::div_fn_t fn,
  input  div_pkg::word_t   a,
  input  div_pkg::word_t   b,
  output div_pkg::result_t result
);
  import div_pkg::*;

  // remainder and quotient halves plus a guard bit for the sign
  localparam int ACC_W = 2 * DIV_STEPS + 1;

  typedef logic [ACC_W-1:0] acc_t;

  // operation flags captured on load
  logic  is_signed;
  logic  a_neg;
  logic  b_neg;

  // iteration registers
  acc_t  rq_reg;
  acc_t  dv_reg;

  // combinational values
  logic  fn_signed;
  word_t a_mag;
  word_t b_mag;
  acc_t  rq_shift;
  acc_t  rq_diff;
  acc_t  rq_next;
  word_t quot_mag;
  word_t rem_mag;
  logic  quot_neg;
  logic  rem_neg;
  word_t quot_out;
  word_t rem_out;

  // ---------------------------------------------------------------------
  // operand normalization
  // ---------------------------------------------------------------------

  assign fn_signed = (fn == DIV_FN_SIGNED);

  // two's complement magnitude
  // most negative value maps to 32'h8000_0000 which is still right unsigned
  assign a_mag = (fn_signed && a[31]) ? (~a + 1'b1) : a;
  assign b_mag = (fn_signed && b[31]) ? (~b + 1'b1) : b;

  // ---------------------------------------------------------------------
  // restoring step
  // ---------------------------------------------------------------------

  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - dv_reg;

  // guard bit set means the subtract went negative
  // so keep the shifted value and shift in a zero
  assign rq_next = rq_diff[ACC_W-1] ? {rq_shift[ACC_W-1:1], 1'b0}
                                    : {rq_diff[ACC_W-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg <= acc_t'(a_mag);
      // divisor lines up with the remainder half
      dv_reg <= {1'b0, b_mag, word_t'(0)};
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_signed <= 1'b0;
      a_neg     <= 1'b0;
      b_neg     <= 1'b0;
    end else if (load) begin
      is_signed <= fn_signed;
      a_neg     <= a[31];
      b_neg     <= b[31];
    end
  end

  // ---------------------------------------------------------------------
  // sign restoration
  // ---------------------------------------------------------------------

  assign quot_mag = rq_reg[DIV_STEPS-1:0];
  assign rem_mag  = rq_reg[2*DIV_STEPS-1:DIV_STEPS];

  // quotient flips when exactly one operand was negative
  assign quot_neg = is_signed && (a_neg ^ b_neg);
  // remainder follows the dividend
  assign rem_neg  = is_signed && a_neg;

  assign quot_out = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  assign result = {rem_out, quot_out};

endmodule

// ==== divider/div_ctrl.sv ====
`timescale 1ns/1ps
/*
  control FSM of the iterative divider with its step counter
  request and response handshakes come from the current state
*/
module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);
  import div_pkg::*;

  localparam int CNT_W = $clog2(DIV_STEPS);

  typedef logic [CNT_W-1:0] step_cnt_t;

  // count value in the final calc cycle
  localparam step_cnt_t LAST_STEP = step_cnt_t'(DIV_STEPS - 1);

  div_state_t state;
  div_state_t state_next;
  step_cnt_t  step_cnt;
  logic       last_step;

  assign last_step = (step_cnt == LAST_STEP);

  // ---------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    load     = 1'b0;
    step     = 1'b0;
    case (state)
      DIV_IDLE: begin
        req_rdy = 1'b1;
        // accept edge loads the datapath
        load    = req_val;
      end
      DIV_CALC: begin
        step = 1'b1;
      end
      DIV_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // ---------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      DIV_IDLE: if (load)      state_next = DIV_CALC;
      DIV_CALC: if (last_step) state_next = DIV_DONE;
      // response leaves when the consumer takes it
      DIV_DONE: if (resp_rdy)  state_next = DIV_IDLE;
      default:                 state_next = DIV_IDLE;
    endcase
  end

  // ---------------------------------------------------------------------
  // state and counter
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
    end else begin
      state <= state_next;
      // counter wraps back to zero on the last step
      if (step) begin
        step_cnt <= last_step ? '0 : step_cnt + step_cnt_t'(1);
      end
    end
  end

endmodule

// ==== rtl/div_req_queue.sv ====
`timescale 1ns/1ps
/*
  circular-buffer request queue in front of the divider
  val/rdy on the request ports and on the outgoing request interface
*/
module div_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  div_pkg::div_fn_t req_fn,
  input  div_pkg::word_t   req_a,
  input  div_pkg::word_t   req_b,
  input  logic             req_val,
  output logic             req_rdy,
  div_req_if.source        deq
);
  import div_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // wrap point for depths that are not a power of two
  localparam ptr_t LAST_SLOT = ptr_t'(QUEUE_DEPTH - 1);
  localparam cnt_t FULL_CNT  = cnt_t'(QUEUE_DEPTH);

  // entry storage
  div_fn_t fn_mem [QUEUE_DEPTH];
  word_t   a_mem  [QUEUE_DEPTH];
  word_t   b_mem  [QUEUE_DEPTH];

  ptr_t    wr_ptr;
  ptr_t    rd_ptr;
  cnt_t    count;
  logic    not_empty;
  logic    push;
  logic    pop;

  // advance a pointer around the ring
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == LAST_SLOT) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_t'(1);
    end
    return nxt;
  endfunction

  // ---------------------------------------------------------------------
  // handshakes
  // ---------------------------------------------------------------------

  assign not_empty = (count != '0);
  assign req_rdy   = (count != FULL_CNT);
  assign push      = req_val && req_rdy;
  assign pop       = not_empty && deq.rdy;

  // oldest entry sits at the read pointer
  assign deq.val   = not_empty;
  assign deq.fn    = fn_mem[rd_ptr];
  assign deq.a     = a_mem[rd_ptr];
  assign deq.b     = b_mem[rd_ptr];

  // ---------------------------------------------------------------------
  // storage and pointers
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      fn_mem[wr_ptr] <= req_fn;
      a_mem[wr_ptr]  <= req_a;
      b_mem[wr_ptr]  <= req_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // push together with pop leaves the occupancy as it was
      case ({push, pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== common/div_req_if.sv ====
`timescale 1ns/1ps
/*
  one divide request moving from the request queue into the divider
  queue side uses the source modport and divider side uses the sink
*/
interface div_req_if;
  import div_pkg::*;

  // request payload
  div_fn_t fn;
  word_t   a;
  word_t   b;

  // val/rdy handshake
  // a transfer happens on an edge with both high
  logic    val;
  logic    rdy;

  // queue side drives the payload and val
  modport source (
    output fn,
    output a,
    output b,
    output val,
    input  rdy
  );

  // divider side answers with rdy
  modport sink (
    input  fn,
    input  a,
    input  b,
    input  val,
    output rdy
  );

endinterface

// ==== common/div_pkg.sv ====
/*
  shared types and constants for the divide unit
  imported by the queue, the request interface and the divider blocks
*/
package div_pkg;

  // ---------------------------------------------------------------------
  // data widths
  // ---------------------------------------------------------------------

  // one operand, quotient or remainder
  typedef logic [31:0] word_t;

  // response word with remainder on top and quotient below
  typedef logic [63:0] result_t;

  // ---------------------------------------------------------------------
  // function encoding
  // ---------------------------------------------------------------------

  typedef logic div_fn_t;

  localparam div_fn_t DIV_FN_UNSIGNED = 1'b0;
  localparam div_fn_t DIV_FN_SIGNED   = 1'b1;

  // ---------------------------------------------------------------------
  // divider control
  // ---------------------------------------------------------------------

  // one restoring step per quotient bit
  localparam int DIV_STEPS = 32;

  // idle waits for a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_CALC,
    DIV_DONE
  } div_state_t;

endpackage
